//--- Bender.yml
package:
  name: ccu

sources:
  - hw/ccu_pkg.sv
  - hw/ccu_req_if.sv
  - hw/ccu_req_arbiter.sv
  - hw/ccu_conflict_table.sv
  - hw/ccu_snoop_ctrl.sv
  - hw/ccu_mem_port.sv
  - hw/ccu_top.sv
  - target: simulation
    files:
      - tb/ccu_tb.sv

//--- hw/ccu_conflict_table.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_conflict_table #(
  parameter int unsigned MemQueueDepth = 2
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           insert_i,
  input  ccu_pkg::addr_t insert_addr_i,
  input  logic           release_i,
  input  ccu_pkg::addr_t lookup_addr_i,
  output logic           lookup_hit_o
);
  import ccu_pkg::*;

  localparam int unsigned PtrWidth = (MemQueueDepth > 1) ? $clog2(MemQueueDepth) : 1;

  logic [MemQueueDepth-1:0] valid_q;
  addr_t                    addr_q [MemQueueDepth];
  logic [PtrWidth-1:0]      wr_ptr_q;
  logic [PtrWidth-1:0]      rd_ptr_q;

  always_comb begin
    lookup_hit_o = 1'b0;
    for (int unsigned i = 0; i < MemQueueDepth; i++) begin
      if (valid_q[i] && addr_q[i] == lookup_addr_i) begin
        lookup_hit_o = 1'b1;
      end
    end
  end

  // Release always retires the oldest entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (insert_i) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MemQueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (release_i) begin
        valid_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MemQueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insert_i) addr_q[wr_ptr_q] <= insert_addr_i;
  end

endmodule

`default_nettype wire

//--- hw/ccu_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_mem_port #(
  parameter int unsigned NumPorts      = 3,
  parameter int unsigned MemQueueDepth = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  ccu_req_if.dst_mp             job,
  output logic                  insert_o,
  output ccu_pkg::addr_t        insert_addr_o,
  output logic                  release_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  output logic                  mem_we_o,
  output ccu_pkg::addr_t        mem_addr_o,
  output ccu_pkg::data_t        mem_wdata_o,
  input  logic                  mem_rsp_valid_i,
  input  ccu_pkg::data_t        mem_rdata_i,
  output logic [NumPorts-1:0]   rsp_valid_o,
  input  logic [NumPorts-1:0]   rsp_ready_i,
  output ccu_pkg::data_t        rsp_data_o
);
  import ccu_pkg::*;

  localparam int unsigned SrcWidth = $clog2(NumPorts);
  localparam int unsigned PtrWidth = (MemQueueDepth > 1) ? $clog2(MemQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(MemQueueDepth + 1);

  ccu_op_e             op_q   [MemQueueDepth];
  addr_t               addr_q [MemQueueDepth];
  data_t               data_q [MemQueueDepth];
  logic [SrcWidth-1:0] src_q  [MemQueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic                issued_q;  // Head access sent to memory
  logic                have_q;    // Head response data ready
  data_t               rsp_data_q;
  logic [SrcWidth-1:0] head_src;
  logic                push;
  logic                pop;

  assign job.ready     = (count_q < CntWidth'(MemQueueDepth));
  assign push          = job.valid && job.ready;
  assign insert_o      = push;
  assign insert_addr_o = job.addr;

  assign head_src        = src_q[rd_ptr_q];
  assign mem_req_valid_o = (count_q != '0) && !issued_q;
  assign mem_we_o        = (op_q[rd_ptr_q] != JobMemRead);
  assign mem_addr_o      = addr_q[rd_ptr_q];
  assign mem_wdata_o     = data_q[rd_ptr_q];

  assign rsp_valid_o = have_q ? (NumPorts'(1) << head_src) : '0;
  assign rsp_data_o  = rsp_data_q;
  assign pop         = have_q && rsp_ready_i[head_src];
  assign release_o   = pop;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      issued_q <= 1'b0;
      have_q   <= 1'b0;
    end else begin
      count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
      if (push) wr_ptr_q <= (wr_ptr_q == PtrWidth'(MemQueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (mem_req_valid_o && mem_req_ready_i) begin
        issued_q <= 1'b1;
        if (mem_we_o) have_q <= 1'b1;  // Writes answer right away
      end
      if (issued_q && !have_q && mem_rsp_valid_i) have_q <= 1'b1;
      if (pop) begin
        issued_q <= 1'b0;
        have_q   <= 1'b0;
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MemQueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]   <= job.op;
      addr_q[wr_ptr_q] <= job.addr;
      data_q[wr_ptr_q] <= job.data;
      src_q[wr_ptr_q]  <= job.src;
    end
    if (mem_req_valid_o && mem_req_ready_i && mem_we_o) begin
      rsp_data_q <= (op_q[rd_ptr_q] == JobForward) ? data_q[rd_ptr_q] : '0;
    end else if (issued_q && !have_q && mem_rsp_valid_i) begin
      rsp_data_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/ccu_pkg.sv
`default_nettype none

package ccu_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Cache request opcodes
  typedef enum logic [1:0] {
    op_read_shared,
    op_read_unique,
    op_write_back
  } ccu_op_e;

  typedef enum logic {
    snp_read_shared,
    snp_read_unique
  } snoop_op_e;

  typedef enum logic [2:0] {
    st_idle,
    st_check,
    st_snoop,
    st_collect,
    st_hand
  } snoop_state_e;

  // Memory job kinds, carried in the op field of the job bus
  localparam ccu_op_e JobMemRead = op_read_shared;  // Fetch line from memory
  localparam ccu_op_e JobForward = op_read_unique;  // Write dirty data, return it
  localparam ccu_op_e JobWrite   = op_write_back;   // Write, respond with zero

endpackage

`default_nettype wire

//--- hw/ccu_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_req_arbiter #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic             [NumPorts-1:0]     req_valid_i,
  output logic             [NumPorts-1:0]     req_ready_o,
  input  ccu_pkg::ccu_op_e [NumPorts-1:0]     req_op_i,
  input  ccu_pkg::addr_t   [NumPorts-1:0]     req_addr_i,
  input  ccu_pkg::data_t   [NumPorts-1:0]     req_data_i,
  ccu_req_if.src_mp                           out
);
  import ccu_pkg::*;

  localparam int unsigned SrcWidth = $clog2(NumPorts);

  logic [SrcWidth-1:0] last_q;
  logic [SrcWidth-1:0] cand;
  logic [SrcWidth-1:0] grant_idx;
  logic                grant_valid;
  logic                can_load;

  assign can_load = !out.valid || out.ready;  // Register empty or draining

  // Search starts one past the last granted port
  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = last_q;
    cand        = last_q;
    for (int unsigned k = 1; k <= NumPorts; k++) begin
      cand = SrcWidth'((int'(last_q) + k) % NumPorts);
      if (!grant_valid && req_valid_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  assign req_ready_o = (grant_valid && can_load) ? (NumPorts'(1) << grant_idx) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out.valid <= 1'b0;
      last_q    <= SrcWidth'(NumPorts - 1);  // Port 0 wins first
    end else if (grant_valid && can_load) begin
      out.valid <= 1'b1;
      last_q    <= grant_idx;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid && can_load) begin
      out.op   <= req_op_i[grant_idx];
      out.addr <= req_addr_i[grant_idx];
      out.data <= req_data_i[grant_idx];
      out.src  <= grant_idx;
    end
  end

endmodule

`default_nettype wire

//--- hw/ccu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ccu_req_if #(
  parameter int unsigned NumPorts = 3
);
  import ccu_pkg::*;

  localparam int unsigned SrcWidth = $clog2(NumPorts);

  logic                valid;
  logic                ready;
  ccu_op_e             op;
  addr_t               addr;
  data_t               data;
  logic [SrcWidth-1:0] src;  // Requesting port

  modport src_mp (output valid, op, addr, data, src, input ready);
  modport dst_mp (input valid, op, addr, data, src, output ready);

endinterface

`default_nettype wire

//--- hw/ccu_snoop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_snoop_ctrl #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  ccu_req_if.dst_mp                         in,
  ccu_req_if.src_mp                         job,
  output ccu_pkg::addr_t                    lookup_addr_o,
  input  logic                              lookup_hit_i,
  output logic           [NumPorts-1:0]     snp_valid_o,
  input  logic           [NumPorts-1:0]     snp_ready_i,
  output ccu_pkg::snoop_op_e                snp_op_o,
  output ccu_pkg::addr_t                    snp_addr_o,
  input  logic           [NumPorts-1:0]     snp_rsp_valid_i,
  input  logic           [NumPorts-1:0]     snp_rsp_dirty_i,
  input  ccu_pkg::data_t [NumPorts-1:0]     snp_rsp_data_i
);
  import ccu_pkg::*;

  localparam int unsigned SrcWidth = $clog2(NumPorts);

  snoop_state_e        state_q;
  ccu_op_e             req_op_q;
  addr_t               req_addr_q;
  data_t               req_data_q;
  logic [SrcWidth-1:0] req_src_q;

  logic [NumPorts-1:0] snp_pend_q;  // Snoop not yet taken
  logic [NumPorts-1:0] ack_pend_q;  // Snoop response outstanding
  logic [NumPorts-1:0] snp_left;
  logic [NumPorts-1:0] ack_left;
  logic [NumPorts-1:0] others;
  logic                dirty_q;
  data_t               dirty_data_q;
  logic                dirty_hit;
  data_t               dirty_sel;

  assign others   = ~(NumPorts'(1) << req_src_q);
  assign snp_left = snp_pend_q & ~snp_ready_i;
  assign ack_left = ack_pend_q & ~snp_rsp_valid_i;

  // Lowest dirty responder this cycle
  always_comb begin
    dirty_hit = 1'b0;
    dirty_sel = '0;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (!dirty_hit && ack_pend_q[p] && snp_rsp_valid_i[p] && snp_rsp_dirty_i[p]) begin
        dirty_hit = 1'b1;
        dirty_sel = snp_rsp_data_i[p];
      end
    end
  end

  assign in.ready      = (state_q == st_idle);
  assign lookup_addr_o = req_addr_q;
  assign snp_valid_o   = snp_pend_q;
  assign snp_addr_o    = req_addr_q;
  assign snp_op_o      = (req_op_q == op_read_unique) ? snp_read_unique : snp_read_shared;

  assign job.valid = (state_q == st_hand);
  assign job.addr  = req_addr_q;
  assign job.src   = req_src_q;
  assign job.op    = (req_op_q == op_write_back) ? JobWrite :
                     dirty_q                     ? JobForward : JobMemRead;
  assign job.data  = (req_op_q == op_write_back) ? req_data_q : dirty_data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= st_idle;
      snp_pend_q <= '0;
      ack_pend_q <= '0;
      dirty_q    <= 1'b0;
    end else begin
      snp_pend_q <= snp_left;
      ack_pend_q <= ack_left;
      if (dirty_hit) dirty_q <= 1'b1;
      case (state_q)
        st_idle: begin
          if (in.valid) begin
            state_q <= st_check;
            dirty_q <= 1'b0;
          end
        end
        st_check: begin
          // Held here while the line is queued at the memory port
          if (!lookup_hit_i) begin
            if (req_op_q == op_write_back) begin
              state_q <= st_hand;
            end else begin
              state_q    <= st_snoop;
              snp_pend_q <= others;
              ack_pend_q <= others;
            end
          end
        end
        st_snoop:   if (snp_left == '0) state_q <= st_collect;
        st_collect: if (ack_left == '0) state_q <= st_hand;
        st_hand:    if (job.ready) state_q <= st_idle;  // Waits on a full queue
        default:    state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (in.valid && in.ready) begin
      req_op_q   <= in.op;
      req_addr_q <= in.addr;
      req_data_q <= in.data;
      req_src_q  <= in.src;
    end
    if (dirty_hit && !dirty_q) dirty_data_q <= dirty_sel;  // First dirty copy wins
  end

endmodule

`default_nettype wire

//--- hw/ccu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_top #(
  parameter int unsigned NumPorts      = 3,
  parameter int unsigned MemQueueDepth = 2
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic               [NumPorts-1:0] req_valid_i,
  output logic               [NumPorts-1:0] req_ready_o,
  input  ccu_pkg::ccu_op_e   [NumPorts-1:0] req_op_i,
  input  ccu_pkg::addr_t     [NumPorts-1:0] req_addr_i,
  input  ccu_pkg::data_t     [NumPorts-1:0] req_data_i,
  output logic               [NumPorts-1:0] rsp_valid_o,
  input  logic               [NumPorts-1:0] rsp_ready_i,
  output ccu_pkg::data_t                    rsp_data_o,
  output logic               [NumPorts-1:0] snp_valid_o,
  input  logic               [NumPorts-1:0] snp_ready_i,
  output ccu_pkg::snoop_op_e                snp_op_o,
  output ccu_pkg::addr_t                    snp_addr_o,
  input  logic               [NumPorts-1:0] snp_rsp_valid_i,
  input  logic               [NumPorts-1:0] snp_rsp_dirty_i,
  input  ccu_pkg::data_t     [NumPorts-1:0] snp_rsp_data_i,
  output logic                              mem_req_valid_o,
  input  logic                              mem_req_ready_i,
  output logic                              mem_we_o,
  output ccu_pkg::addr_t                    mem_addr_o,
  output ccu_pkg::data_t                    mem_wdata_o,
  input  logic                              mem_rsp_valid_i,
  input  ccu_pkg::data_t                    mem_rdata_i
);
  import ccu_pkg::*;

  addr_t lookup_addr;
  logic  lookup_hit;
  logic  insert;
  addr_t insert_addr;
  logic  release_entry;

  ccu_req_if #(.NumPorts(NumPorts)) req_bus ();
  ccu_req_if #(.NumPorts(NumPorts)) job_bus ();  // Snoop controller to memory port

  ccu_req_arbiter #(
    .NumPorts    (NumPorts)
  ) u_arbiter (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_ready_o,
    .req_op_i,
    .req_addr_i,
    .req_data_i,
    .out         (req_bus)
  );

  ccu_snoop_ctrl #(
    .NumPorts        (NumPorts)
  ) u_snoop_ctrl (
    .clk_i,
    .reset_i,
    .in              (req_bus),
    .job             (job_bus),
    .lookup_addr_o   (lookup_addr),
    .lookup_hit_i    (lookup_hit),
    .snp_valid_o,
    .snp_ready_i,
    .snp_op_o,
    .snp_addr_o,
    .snp_rsp_valid_i,
    .snp_rsp_dirty_i,
    .snp_rsp_data_i
  );

  ccu_conflict_table #(
    .MemQueueDepth (MemQueueDepth)
  ) u_conflict_table (
    .clk_i,
    .reset_i,
    .insert_i      (insert),
    .insert_addr_i (insert_addr),
    .release_i     (release_entry),
    .lookup_addr_i (lookup_addr),
    .lookup_hit_o  (lookup_hit)
  );

  ccu_mem_port #(
    .NumPorts        (NumPorts),
    .MemQueueDepth   (MemQueueDepth)
  ) u_mem_port (
    .clk_i,
    .reset_i,
    .job             (job_bus),
    .insert_o        (insert),
    .insert_addr_o   (insert_addr),
    .release_o       (release_entry),
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_rsp_valid_i,
    .mem_rdata_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_data_o
  );

endmodule

`default_nettype wire

//--- list.f
hw/ccu_pkg.sv
hw/ccu_req_if.sv
hw/ccu_req_arbiter.sv
hw/ccu_conflict_table.sv
hw/ccu_snoop_ctrl.sv
hw/ccu_mem_port.sv
hw/ccu_top.sv
tb/ccu_tb.sv

//--- tb/ccu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_tb;
  import ccu_pkg::*;

  localparam int unsigned NumPorts       = 3;
  localparam int unsigned MemQueueDepth  = 2;
  localparam int unsigned SrcWidth       = $clog2(NumPorts);
  localparam int unsigned DirectedReqs   = 20;
  localparam int unsigned RandomReqs     = 200;
  localparam int unsigned WatchdogCycles = 400 * (DirectedReqs + RandomReqs) + 20;

  typedef struct packed {
    ccu_op_e op;
    addr_t   addr;
    data_t   data;
  } req_t;

  typedef struct packed {
    logic [SrcWidth-1:0] src;
    ccu_op_e             op;
    addr_t               addr;
  } snp_exp_t;

  logic                          clk_i;
  logic                          reset_i;
  logic               [NumPorts-1:0] req_valid_i;
  logic               [NumPorts-1:0] req_ready_o;
  ccu_op_e            [NumPorts-1:0] req_op_i;
  addr_t              [NumPorts-1:0] req_addr_i;
  data_t              [NumPorts-1:0] req_data_i;
  logic               [NumPorts-1:0] rsp_valid_o;
  logic               [NumPorts-1:0] rsp_ready_i;
  data_t                             rsp_data_o;
  logic               [NumPorts-1:0] snp_valid_o;
  logic               [NumPorts-1:0] snp_ready_i;
  snoop_op_e                         snp_op_o;
  addr_t                             snp_addr_o;
  logic               [NumPorts-1:0] snp_rsp_valid_i;
  logic               [NumPorts-1:0] snp_rsp_dirty_i;
  data_t              [NumPorts-1:0] snp_rsp_data_i;
  logic                              mem_req_valid_o;
  logic                              mem_req_ready_i;
  logic                              mem_we_o;
  addr_t                             mem_addr_o;
  data_t                             mem_wdata_o;
  logic                              mem_rsp_valid_i;
  data_t                             mem_rdata_i;

  data_t    mem_model [addr_t];
  data_t    ref_mem   [addr_t];            // Reference memory contents
  data_t    cache_dirty [NumPorts][addr_t];
  data_t    ref_dirty   [NumPorts][addr_t];
  req_t     req_q [NumPorts][$];
  data_t    exp_q [NumPorts][$];           // Expected response data per port
  snp_exp_t snp_exp_q [$];

  logic [NumPorts-1:0] req_taken = '0;
  logic [NumPorts-1:0] snp_mask  = '0;
  logic [NumPorts-1:0] snp_prev  = '0;
  logic                req_seen  = 1'b0;
  logic                models_on = 1'b0;
  int unsigned         wait_grants [NumPorts];
  int unsigned         snp_wait [NumPorts];
  logic                snp_dirty_r [NumPorts];
  data_t               snp_data_r [NumPorts];
  int unsigned         mem_wait    = 0;
  data_t               mem_rd_data = '0;
  int unsigned         total_sent  = 0;
  int unsigned         total_done  = 0;

  ccu_top #(
    .NumPorts      (NumPorts),
    .MemQueueDepth (MemQueueDepth)
  ) u_ccu_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  // Unwritten lines read as a hash of the full address
  function automatic data_t mem_fill(input addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h0f1e2d3c;
  endfunction

  function automatic data_t mem_value(input addr_t a);
    return mem_model.exists(a) ? mem_model[a] : mem_fill(a);
  endfunction

  task automatic queue_req(input int p, input ccu_op_e op, input addr_t a, input data_t d);
    req_t r;
    r.op   = op;
    r.addr = a;
    r.data = d;
    req_q[p].push_back(r);
    total_sent++;
  endtask

  task automatic preload_dirty(input int p, input addr_t a, input data_t d);
    cache_dirty[p][a] = d;
    ref_dirty[p][a]   = d;
  endtask

  task automatic wait_drain();
    do @(negedge clk_i); while (total_done != total_sent);
  endtask

  // Reference step applied in grant order
  task automatic model_request(input int p, input req_t r);
    data_t    exp;
    logic     found;
    snp_exp_t e;
    found = 1'b0;
    exp   = ref_mem.exists(r.addr) ? ref_mem[r.addr] : mem_fill(r.addr);
    if (r.op == op_write_back) begin
      exp             = '0;
      ref_mem[r.addr] = r.data;
    end else begin
      for (int q = 0; q < NumPorts; q++) begin
        if (q != p && ref_dirty[q].exists(r.addr)) begin
          found = 1'b1;
          exp   = ref_dirty[q][r.addr];
          if (r.op == op_read_unique) ref_dirty[q].delete(r.addr);
        end
      end
      if (found) ref_mem[r.addr] = exp;  // Forwarded copy lands in memory
      e.src  = SrcWidth'(p);
      e.op   = r.op;
      e.addr = r.addr;
      snp_exp_q.push_back(e);
    end
    exp_q[p].push_back(exp);
  endtask

  task automatic check_state();
    data_t lines [addr_t];
    assert (mem_model.num() == ref_mem.num())
      else report_failure($sformatf("error %0t: memory holds %0d lines, expected %0d",
                                    $time, mem_model.num(), ref_mem.num()));
    foreach (ref_mem[a]) begin
      assert (mem_value(a) == ref_mem[a])
        else report_failure($sformatf("error %0t: memory line %h holds %h, expected %h",
                                      $time, a, mem_value(a), ref_mem[a]));
    end
    for (int p = 0; p < NumPorts; p++) begin
      lines = ref_dirty[p];
      assert (cache_dirty[p].num() == lines.num())
        else report_failure($sformatf("error %0t: cache %0d holds %0d dirty lines, expected %0d",
                                      $time, p, cache_dirty[p].num(), lines.num()));
      foreach (lines[a]) begin
        assert (cache_dirty[p].exists(a) && cache_dirty[p][a] == lines[a])
          else report_failure($sformatf("error %0t: cache %0d line %h lost or changed",
                                        $time, p, a));
      end
    end
    assert (snp_exp_q.size() == 0) else report_failure("a read finished without a snoop");
  endtask

  assert property (@(posedge clk_i) disable iff (reset_i)
      !req_seen |-> (rsp_valid_o == '0 && snp_valid_o == '0 && !mem_req_valid_o &&
                     req_ready_o == '0))
    else report_failure("a valid output rose before the first request");

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(rsp_valid_o))
    else report_failure("more than one port saw a response at once");

  always @(posedge clk_i) begin : sample_outputs
    req_t      r;
    snp_exp_t  e;
    snoop_op_e exp_snp;
    data_t     got;
    if (!reset_i) begin
      if (mem_req_valid_o && mem_req_ready_i) begin
        if (mem_we_o) begin
          mem_model[mem_addr_o] = mem_wdata_o;
        end else begin
          mem_rd_data = mem_value(mem_addr_o);
          mem_wait    = 1 + $urandom % 4;
        end
      end
      if (snp_valid_o != '0 && snp_prev == '0) begin  // New broadcast
        assert (snp_exp_q.size() > 0) else report_failure("snoop seen with no read pending");
        e        = snp_exp_q.pop_front();
        snp_mask = ~(NumPorts'(1) << e.src);
        exp_snp  = (e.op == op_read_unique) ? snp_read_unique : snp_read_shared;
        assert (snp_valid_o == snp_mask && snp_addr_o == e.addr && snp_op_o == exp_snp)
          else report_failure($sformatf(
            "error %0t: snoop mask %b addr %h op %0d, expected mask %b addr %h op %0d",
            $time, snp_valid_o, snp_addr_o, snp_op_o, snp_mask, e.addr, exp_snp));
      end
      assert ((snp_valid_o & ~snp_mask) == '0)
        else report_failure($sformatf("error %0t: snoop valid %b outside mask %b",
                                      $time, snp_valid_o, snp_mask));
      snp_prev = snp_valid_o;
      for (int p = 0; p < NumPorts; p++) begin
        if (snp_valid_o[p] && snp_ready_i[p]) begin
          snp_dirty_r[p] = cache_dirty[p].exists(snp_addr_o);
          snp_data_r[p]  = snp_dirty_r[p] ? cache_dirty[p][snp_addr_o] : '0;
          if (snp_op_o == snp_read_unique) cache_dirty[p].delete(snp_addr_o);
          snp_wait[p] = 1 + $urandom % 3;
        end
        if (rsp_valid_o[p] && rsp_ready_i[p]) begin
          assert (exp_q[p].size() > 0)
            else report_failure($sformatf("port %0d got a response it never asked for", p));
          got = exp_q[p].pop_front();
          assert (rsp_data_o == got)
            else report_failure($sformatf("error %0t: port %0d response %h, expected %h",
                                          $time, p, rsp_data_o, got));
          total_done++;
        end
        if (req_valid_i[p] && req_ready_o[p]) begin
          r.op   = req_op_i[p];
          r.addr = req_addr_i[p];
          r.data = req_data_i[p];
          model_request(p, r);
          req_taken[p]   = 1'b1;
          wait_grants[p] = 0;
        end else if (req_valid_i[p] && req_ready_o != '0) begin
          wait_grants[p]++;
          assert (wait_grants[p] < NumPorts)
            else report_failure($sformatf("error %0t: port %0d passed over %0d times",
                                          $time, p, wait_grants[p]));
        end else if (!req_valid_i[p]) begin
          wait_grants[p] = 0;
        end
      end
    end
  end

  always @(negedge clk_i) begin : drive_inputs
    req_t r;
    if (models_on) begin
      mem_req_ready_i = ($urandom % 3) != 0;
      mem_rsp_valid_i = 1'b0;
      if (mem_wait > 0) begin
        mem_wait--;
        if (mem_wait == 0) begin
          mem_rsp_valid_i = 1'b1;
          mem_rdata_i     = mem_rd_data;
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        rsp_ready_i[p]     = ($urandom % 4) != 0;
        snp_ready_i[p]     = ($urandom % 2) != 0;
        snp_rsp_valid_i[p] = 1'b0;
        if (snp_wait[p] > 0) begin
          snp_wait[p]--;
          if (snp_wait[p] == 0) begin
            snp_rsp_valid_i[p] = 1'b1;
            snp_rsp_dirty_i[p] = snp_dirty_r[p];
            snp_rsp_data_i[p]  = snp_data_r[p];
          end
        end
        if (req_taken[p]) begin
          req_valid_i[p] = 1'b0;
          req_taken[p]   = 1'b0;
        end
        if (!req_valid_i[p] && req_q[p].size() > 0) begin
          r              = req_q[p].pop_front();
          req_op_i[p]    = r.op;
          req_addr_i[p]  = r.addr;
          req_data_i[p]  = r.data;
          req_valid_i[p] = 1'b1;
          req_seen       = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    report_failure($sformatf("watchdog timeout after %0d cycles, %0d of %0d responses seen",
                             WatchdogCycles, total_done, total_sent));
  end

  initial begin : run_tests
    void'($urandom(32'h4c61444d));
    reset_i         = 1'b1;
    req_valid_i     = '0;
    req_addr_i      = '0;
    req_data_i      = '0;
    rsp_ready_i     = '0;
    snp_ready_i     = '0;
    snp_rsp_valid_i = '0;
    snp_rsp_dirty_i = '0;
    snp_rsp_data_i  = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rdata_i     = '0;
    for (int p = 0; p < NumPorts; p++) begin
      req_op_i[p]    = op_read_shared;
      wait_grants[p] = 0;
      snp_wait[p]    = 0;
      snp_dirty_r[p] = 1'b0;
      snp_data_r[p]  = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    @(posedge clk_i);
    models_on = 1'b1;
    repeat (5) @(negedge clk_i);  // Idle outputs must stay quiet

    // Misses go to memory
    @(posedge clk_i);
    queue_req(0, op_read_shared, 32'h10, '0);
    queue_req(1, op_read_unique, 32'h14, '0);
    wait_drain();
    check_state();

    // Dirty hits by read_shared then read_unique
    preload_dirty(1, 32'h20, 32'hdead0001);
    preload_dirty(2, 32'h24, 32'hbeef0002);
    @(posedge clk_i);
    queue_req(0, op_read_shared, 32'h20, '0);
    queue_req(0, op_read_unique, 32'h24, '0);
    wait_drain();
    check_state();
    @(posedge clk_i);
    queue_req(1, op_read_shared, 32'h24, '0);  // Now served from memory
    wait_drain();
    check_state();

    // Write-back then back-to-back reads of the same line
    @(posedge clk_i);
    queue_req(2, op_write_back, 32'h30, 32'h12345678);
    queue_req(0, op_read_shared, 32'h30, '0);
    queue_req(1, op_read_unique, 32'h30, '0);
    wait_drain();
    check_state();

    // All ports busy at once
    @(posedge clk_i);
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < NumPorts; p++) begin
        queue_req(p, ccu_op_e'(2'((i + p) % 3)), addr_t'(32'h40 + 16 * i + 4 * p),
                  data_t'($urandom));
      end
    end
    wait_drain();
    check_state();

    // Random traffic over 8 lines with at most one dirty holder each
    for (int i = 0; i < 8; i++) begin
      if ($urandom % 3 == 0) begin
        preload_dirty(int'($urandom % NumPorts), addr_t'(32'h100 + 4 * i), data_t'($urandom));
      end
    end
    @(posedge clk_i);
    for (int i = 0; i < RandomReqs; i++) begin
      queue_req(int'($urandom % NumPorts), ccu_op_e'(2'($urandom % 3)),
                addr_t'(32'h100 + 4 * ($urandom % 8)), data_t'($urandom));
    end
    wait_drain();
    check_state();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
